/* posit_pkg.sv */
// Shared widths and constants for the posit<32,3> adder
// Field widths, scale range and pipeline latency

package posit_pkg;

    // Posit format
    localparam int NBITS = 32;
    localparam int ES    = 3;

    // Fraction field without the hidden bit (sign, shortest regime and terminator removed)
    localparam int FBITS = NBITS - ES - 3;

    // Working fraction: hidden bit, fraction and three guard positions
    localparam int ABITS = FBITS + 4;

    // Signed scale, regime * 2^ES + exponent
    localparam int SBITS = 9;

    // Largest and smallest scale of a representable nonzero posit
    localparam int SCALE_MAX = (NBITS - 2) << ES;   // maxpos = 2^240
    localparam int SCALE_MIN = -SCALE_MAX;          // minpos = 2^-240

    // Exponent plus normalized fraction string used while packing
    localparam int EBITS = ES + ABITS + 1;

    // Regime run, terminator, exponent and fraction before the regime shift
    localparam int PACK_BITS = NBITS + EBITS;

    // Cycles from start to done
    localparam int LATENCY = 8;

    // Not-a-Real pattern
    localparam logic [NBITS-1:0] NAR = {1'b1, {(NBITS-1){1'b0}}};

endpackage

/* posit_extract.sv */
// Posit decoder: sign, zero and NaR flags, signed scale, fraction and magnitude
`timescale 1ns/10ps

module posit_extract import posit_pkg::*;
(
    input  logic [NBITS-1:0]        in,
    output logic                    sign,
    output logic                    zero,
    output logic                    inf,
    output logic signed [SBITS-1:0] scale,
    output logic [FBITS-1:0]        fraction,
    output logic [NBITS-2:0]        magnitude
);

    logic [5:0]                 run_len;    // Bits in the regime run
    logic                       in_run;
    logic signed [SBITS-ES-1:0] regime;
    logic [NBITS-2:0]           remainder;  // Exponent and fraction, left-aligned
    logic [ES-1:0]              exponent;

    assign sign = in[NBITS-1];
    assign zero = (in == '0);
    assign inf  = (in == NAR);

    // Negative posits are decoded from their two's complement
    assign magnitude = sign ? -in[NBITS-2:0] : in[NBITS-2:0];

    // Count the run of identical bits after the sign
    always_comb
    begin
        run_len = 6'd1;
        in_run  = 1'b1;
        for (int i = NBITS - 3; i >= 0; i--)
        begin
            if (in_run && (magnitude[i] == magnitude[NBITS-2]))
                run_len = run_len + 6'd1;
            else
                in_run = 1'b0;
        end
    end

    // A run of ones gives k-1, a run of zeros gives -k
    assign regime = magnitude[NBITS-2] ? (SBITS-ES)'(run_len - 6'd1)
                                       : -(SBITS-ES)'(run_len);

    // Drop the run and its terminating bit
    assign remainder = magnitude << (run_len + 6'd1);

    assign exponent = remainder[NBITS-2 -: ES];
    assign fraction = remainder[NBITS-2-ES -: FBITS];

    assign scale = {regime, exponent};   // regime * 2^ES + exponent

endmodule

/* leading_one_detect.sv */
// Leading zero count of the raw fraction sum
`timescale 1ns/10ps

module leading_one_detect import posit_pkg::*;
(
    input  logic [ABITS:0] in,
    output logic [4:0]     position,
    output logic           none
);

    // Scan upwards so the highest set bit wins
    always_comb
    begin
        position = '0;
        none     = 1'b1;
        for (int i = 0; i <= ABITS; i++)
        begin
            if (in[i])
            begin
                position = 5'(ABITS - i);
                none     = 1'b0;
            end
        end
    end

endmodule

/* posit_align_add.sv */
// Front half of the posit adder: decode, ordering, alignment, add/subtract
// and normalization over stages 0, 1, 1b, 2 and 2b
`timescale 1ns/10ps

module posit_align_add import posit_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    start,
    input  logic [NBITS-1:0]        in1,
    input  logic [NBITS-1:0]        in2,
    output logic                    norm_valid,
    output logic                    sum_sign,
    output logic signed [SBITS-1:0] sum_scale,
    output logic                    sum_zero,
    output logic                    sum_inf,
    output logic [ABITS:0]          fraction_normalized,
    output logic                    truncated,
    output logic                    rounded_zero
);

    // Stage 0
    logic                    r0_valid;
    logic [NBITS-1:0]        r0_in1, r0_in2;
    logic                    a_sign, a_zero, a_inf, b_sign, b_zero, b_inf;
    logic signed [SBITS-1:0] a_scale, b_scale;
    logic [FBITS-1:0]        a_frac, b_frac;
    logic [NBITS-2:0]        a_mag, b_mag;
    logic                    a_is_hi;

    // Stage 1
    logic                    r1_valid, r1_sub, r1_zero, r1_inf;
    logic                    r1_hi_sign, r1_hi_zero, r1_lo_zero;
    logic signed [SBITS-1:0] r1_hi_scale, r1_lo_scale;
    logic [FBITS-1:0]        r1_hi_frac, r1_lo_frac;
    logic [SBITS:0]          scale_diff;
    logic [2*ABITS-1:0]      lo_wide;
    logic [ABITS-1:0]        hi_word;
    logic                    r1_trunc;
    logic [ABITS:0]          sum_raw;

    // Stages 1b and 2
    logic                    r1b_valid, r1b_sign, r1b_zero, r1b_inf, r1b_trunc;
    logic signed [SBITS-1:0] r1b_hi_scale;
    logic [ABITS:0]          r1b_sum_raw;
    logic [4:0]              lz;
    logic                    lz_none;
    logic signed [SBITS+1:0] scale_wide;
    logic signed [SBITS-1:0] scale_adj;
    logic                    r2_valid, r2_sign, r2_zero, r2_inf, r2_trunc, r2_rounded_zero;
    logic signed [SBITS-1:0] r2_scale;
    logic [ABITS:0]          r2_sum_raw;
    logic [4:0]              r2_shift;

    posit_extract u_extract_a
    (
        .in        (r0_in1),
        .sign      (a_sign),
        .zero      (a_zero),
        .inf       (a_inf),
        .scale     (a_scale),
        .fraction  (a_frac),
        .magnitude (a_mag)
    );

    posit_extract u_extract_b
    (
        .in        (r0_in2),
        .sign      (b_sign),
        .zero      (b_zero),
        .inf       (b_inf),
        .scale     (b_scale),
        .fraction  (b_frac),
        .magnitude (b_mag)
    );

    // Posit magnitudes order the same way as their encodings
    assign a_is_hi = (a_mag >= b_mag);

    // Smaller operand is shifted right by the scale difference
    assign scale_diff = {r1_hi_scale[SBITS-1], r1_hi_scale} - {r1_lo_scale[SBITS-1], r1_lo_scale};
    assign lo_wide    = {~r1_lo_zero, r1_lo_frac, {(ABITS-FBITS-1){1'b0}}, {ABITS{1'b0}}}
                        >> scale_diff;
    assign r1_trunc   = |lo_wide[ABITS-1:0];
    assign hi_word    = {~r1_hi_zero, r1_hi_frac, {(ABITS-FBITS-1){1'b0}}};

    // Lost bits in a subtraction borrow one LSB and stay sticky
    assign sum_raw = r1_sub ? {1'b0, hi_word} - {1'b0, lo_wide[2*ABITS-1:ABITS]}
                              - {{ABITS{1'b0}}, r1_trunc}
                            : {1'b0, hi_word} + {1'b0, lo_wide[2*ABITS-1:ABITS]};

    leading_one_detect u_lod
    (
        .in       (r1b_sum_raw),
        .position (lz),
        .none     (lz_none)
    );

    // Hidden bit normally sits at ABITS-1; a carry adds one, cancellation subtracts
    assign scale_wide = $signed({{2{r1b_hi_scale[SBITS-1]}}, r1b_hi_scale}) + 11'sd1
                        - $signed({{(SBITS-3){1'b0}}, lz});

    always_comb
    begin
        if (scale_wide > SCALE_MAX)
            scale_adj = SBITS'(SCALE_MAX);   // Saturates to maxpos when packed
        else if (scale_wide < SCALE_MIN)
            scale_adj = SBITS'(SCALE_MIN);
        else
            scale_adj = scale_wide[SBITS-1:0];
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            r0_valid   <= 1'b0;
            r1_valid   <= 1'b0;
            r1b_valid  <= 1'b0;
            r2_valid   <= 1'b0;
            norm_valid <= 1'b0;
        end
        else
        begin
            r0_valid   <= start;
            r1_valid   <= r0_valid;
            r1b_valid  <= r1_valid;
            r2_valid   <= r1b_valid;
            norm_valid <= r2_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        r0_in1 <= in1;
        r0_in2 <= in2;

        r1_hi_sign  <= a_is_hi ? a_sign  : b_sign;
        r1_hi_zero  <= a_is_hi ? a_zero  : b_zero;
        r1_hi_scale <= a_is_hi ? a_scale : b_scale;
        r1_hi_frac  <= a_is_hi ? a_frac  : b_frac;
        r1_lo_zero  <= a_is_hi ? b_zero  : a_zero;
        r1_lo_scale <= a_is_hi ? b_scale : a_scale;
        r1_lo_frac  <= a_is_hi ? b_frac  : a_frac;
        r1_sub      <= a_sign ^ b_sign;   // Unequal signs subtract
        r1_zero     <= a_zero & b_zero;
        r1_inf      <= a_inf | b_inf;

        r1b_sum_raw  <= sum_raw;
        r1b_trunc    <= r1_trunc;
        r1b_sign     <= r1_hi_sign;
        r1b_hi_scale <= r1_hi_scale;
        r1b_zero     <= r1_zero;
        r1b_inf      <= r1_inf;

        r2_sum_raw      <= r1b_sum_raw;
        r2_shift        <= lz + 5'd1;   // Hidden bit is shifted out as well
        r2_scale        <= scale_adj;
        r2_sign         <= r1b_sign;
        r2_zero         <= r1b_zero;
        r2_inf          <= r1b_inf;
        r2_trunc        <= r1b_trunc;
        r2_rounded_zero <= lz_none;     // Full cancellation

        fraction_normalized <= r2_sum_raw << r2_shift;
        sum_sign            <= r2_sign;
        sum_scale           <= r2_scale;
        sum_zero            <= r2_zero;
        sum_inf             <= r2_inf;
        truncated           <= r2_trunc;
        rounded_zero        <= r2_rounded_zero;
    end

endmodule

/* posit_round_pack.sv */
// Back half of the posit adder: regime packing, sticky and guard bits,
// round-to-nearest-even, sign and the output register
`timescale 1ns/10ps

module posit_round_pack import posit_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    norm_valid,
    input  logic                    sum_sign,
    input  logic signed [SBITS-1:0] sum_scale,
    input  logic                    sum_zero,
    input  logic                    sum_inf,
    input  logic [ABITS:0]          fraction_normalized,
    input  logic                    truncated,
    input  logic                    rounded_zero,
    output logic [NBITS-1:0]        result,
    output logic                    inf,
    output logic                    zero,
    output logic                    done
);

    logic signed [SBITS-1:0] regime;
    logic                    regime_neg;
    logic [4:0]              regime_shift;
    logic [PACK_BITS-1:0]    pack_vec;

    logic                    r3_valid, r3_sign, r3_zero, r3_inf, r3_trunc, r3_rounded_zero;
    logic [PACK_BITS-1:0]    r3_pack;
    logic [4:0]              r3_shift;
    logic [PACK_BITS-1:0]    shifted;
    logic                    lost;        // Bits pushed out by the regime shift

    logic                    r3b_valid, r3b_sign, r3b_zero, r3b_inf, r3b_rounded_zero;
    logic [NBITS-2:0]        r3b_kept;
    logic                    r3b_bafter, r3b_sticky;
    logic                    round_up;
    logic [NBITS-2:0]        rounded;
    logic [NBITS-2:0]        signed_mag;

    // Regime value and the length of the regime field
    assign regime       = sum_scale >>> ES;
    assign regime_neg   = sum_scale[SBITS-1];
    assign regime_shift = regime_neg ? 5'(-regime) : 5'(regime + 1);

    // Run bits, terminator, exponent, fraction
    assign pack_vec = {{(NBITS-1){~regime_neg}}, regime_neg, sum_scale[ES-1:0],
                       fraction_normalized};

    assign shifted = r3_pack >> r3_shift;
    assign lost    = |(r3_pack[EBITS-1:0] & ~({EBITS{1'b1}} << r3_shift));

    // Tie goes to the even encoding
    assign round_up   = r3b_bafter & (r3b_sticky | r3b_kept[0]);
    assign rounded    = r3b_kept + {{(NBITS-2){1'b0}}, round_up};
    assign signed_mag = r3b_sign ? -rounded : rounded;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            r3_valid  <= 1'b0;
            r3b_valid <= 1'b0;
            done      <= 1'b0;
        end
        else
        begin
            r3_valid  <= norm_valid;
            r3b_valid <= r3_valid;
            done      <= r3b_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        r3_pack         <= pack_vec;
        r3_shift        <= regime_shift;
        r3_sign         <= sum_sign;
        r3_zero         <= sum_zero;
        r3_inf          <= sum_inf;
        r3_trunc        <= truncated;
        r3_rounded_zero <= rounded_zero;

        r3b_kept   <= shifted[EBITS -: NBITS-1];
        r3b_bafter <= shifted[EBITS-NBITS+1];
        r3b_sticky <= |shifted[EBITS-NBITS:0] | lost | r3_trunc;
        r3b_sign   <= r3_sign;
        r3b_zero   <= r3_zero;
        r3b_inf    <= r3_inf;
        r3b_rounded_zero <= r3_rounded_zero;

        // Outputs hold between dones
        if (r3b_valid)
        begin
            // NaR wins over zero
            if (r3b_inf)
                result <= NAR;
            else if (r3b_zero || r3b_rounded_zero)
                result <= '0;
            else
                result <= {r3b_sign, signed_mag};
            inf  <= r3b_inf;
            zero <= ~r3b_inf & (r3b_zero | r3b_rounded_zero);
        end
    end

endmodule

/* posit_add_top.sv */
// Top level of the pipelined posit<32,3> adder
`timescale 1ns/10ps

module posit_add_top import posit_pkg::*;
(
    input  logic             clk,
    input  logic             arst_n,
    input  logic             start,
    input  logic [NBITS-1:0] in1,
    input  logic [NBITS-1:0] in2,
    output logic [NBITS-1:0] result,
    output logic             inf,
    output logic             zero,
    output logic             done
);

    // Stage 2b boundary
    logic                    norm_valid;
    logic                    sum_sign;
    logic signed [SBITS-1:0] sum_scale;
    logic                    sum_zero;
    logic                    sum_inf;
    logic [ABITS:0]          fraction_normalized;
    logic                    truncated;
    logic                    rounded_zero;

    posit_align_add u_align_add
    (
        .clk                 (clk),
        .arst_n              (arst_n),
        .start               (start),
        .in1                 (in1),
        .in2                 (in2),
        .norm_valid          (norm_valid),
        .sum_sign            (sum_sign),
        .sum_scale           (sum_scale),
        .sum_zero            (sum_zero),
        .sum_inf             (sum_inf),
        .fraction_normalized (fraction_normalized),
        .truncated           (truncated),
        .rounded_zero        (rounded_zero)
    );

    posit_round_pack u_round_pack
    (
        .clk                 (clk),
        .arst_n              (arst_n),
        .norm_valid          (norm_valid),
        .sum_sign            (sum_sign),
        .sum_scale           (sum_scale),
        .sum_zero            (sum_zero),
        .sum_inf             (sum_inf),
        .fraction_normalized (fraction_normalized),
        .truncated           (truncated),
        .rounded_zero        (rounded_zero),
        .result              (result),
        .inf                 (inf),
        .zero                (zero),
        .done                (done)
    );

endmodule

/* tb_clock_gen.sv */
// Testbench clock and reset source
`timescale 1ns/10ps

module tb_clock_gen
(
    output logic clk,
    output logic arst_n
);

    // 20 ns period
    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        arst_n = 1'b0;
        repeat (3) @(posedge clk);   // Three cycles in reset
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

/* posit_add_checker.sv */
// Scoreboard for the posit adder
// Queues expected values on start, compares them on done
`timescale 1ns/10ps

module posit_add_checker import posit_pkg::*;
#(
    parameter int NAME_W = 8 * 24
)
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              start,
    input  logic [NAME_W-1:0] test_name,
    input  logic [NBITS-1:0]  exp_result,
    input  logic              exp_inf,
    input  logic              exp_zero,
    input  logic              done,
    input  logic [NBITS-1:0]  result,
    input  logic              inf,
    input  logic              zero,
    output int                mismatches,
    output int                stray_dones,
    output int                pending
);

    logic [NAME_W-1:0] q_name[$];
    logic [NBITS-1:0]  q_result[$];
    logic              q_inf[$];
    logic              q_zero[$];

    task automatic compare_value(input logic [NAME_W-1:0] name, input string field,
                                 input logic [NBITS-1:0] expected,
                                 input logic [NBITS-1:0] actual);
        if (actual !== expected)
        begin
            $display("Mismatch in %0s, %0s: expected %h, actual %h",
                     name, field, expected, actual);
            mismatches++;
        end
    endtask

    initial
    begin
        mismatches  = 0;
        stray_dones = 0;
        pending     = 0;
    end

    always @(posedge clk)
    begin : sample
        logic [NAME_W-1:0] name;
        if (arst_n)
        begin
            // Pop before push so a done never matches the start of the same edge
            if (done && q_name.size() == 0)
            begin
                $display("A done strobe arrived with no start outstanding at %0t", $time);
                stray_dones++;
            end
            else if (done)
            begin
                name = q_name.pop_front();
                compare_value(name, "result", q_result.pop_front(), result);
                compare_value(name, "inf", q_inf.pop_front(), inf);
                compare_value(name, "zero", q_zero.pop_front(), zero);
            end
            if (start)
            begin
                q_name.push_back(test_name);
                q_result.push_back(exp_result);
                q_inf.push_back(exp_inf);
                q_zero.push_back(exp_zero);
            end
        end
        pending = q_name.size();
    end

endmodule

/* posit_add_sva.sv */
// Strobe latency and output flag assertions, bound to the adder top level
`timescale 1ns/10ps

module posit_add_sva import posit_pkg::*;
(
    input logic             clk,
    input logic             arst_n,
    input logic             start,
    input logic             done,
    input logic [NBITS-1:0] result,
    input logic             inf,
    input logic             zero
);

    int failures = 0;

    task automatic record_failure(input string what);
        failures++;
        $error("%s", what);
    endtask

    // Fixed pipeline depth, checked in both directions
    start_to_done: assert property (@(posedge clk) disable iff (!arst_n) start |-> ##LATENCY done)
        else record_failure("done did not follow start after LATENCY cycles");
    done_from_start: assert property (@(posedge clk) disable iff (!arst_n)
                                      done |-> $past(start, LATENCY))
        else record_failure("done without a start LATENCY cycles earlier");

    flags_exclusive: assert property (@(posedge clk) disable iff (!arst_n) done |-> !(inf && zero))
        else record_failure("inf and zero both high");
    inf_is_nar: assert property (@(posedge clk) disable iff (!arst_n) (done && inf) |-> result == NAR)
        else record_failure("inf high but result is not NaR");

    done_in_reset: assert property (@(posedge clk) !arst_n |-> !done)
        else record_failure("done high during reset");

endmodule

bind posit_add_top posit_add_sva u_sva
(
    .clk    (clk),
    .arst_n (arst_n),
    .start  (start),
    .done   (done),
    .result (result),
    .inf    (inf),
    .zero   (zero)
);

/* posit_add_tb.sv */
// Testbench top for the posit<32,3> adder
// Stimulus table, LFSR idle gaps, drive loop and final report
`timescale 1ns/10ps

module posit_add_tb import posit_pkg::*; ();

    localparam int NAME_W      = 8 * 24;
    localparam int RESET_LIMIT = 20;
    localparam int DRAIN_LIMIT = 4 * LATENCY;

    logic              clk;
    logic              arst_n;
    logic              start;
    logic [NBITS-1:0]  in1;
    logic [NBITS-1:0]  in2;
    logic [NBITS-1:0]  result;
    logic              inf;
    logic              zero;
    logic              done;
    logic [NAME_W-1:0] test_name;
    logic [NBITS-1:0]  exp_result;
    logic              exp_inf;
    logic              exp_zero;
    int                mismatches;
    int                stray_dones;
    int                pending;
    int                timeouts;
    logic [15:0]       lfsr_state;

    // Stimulus and expected values, one entry per start
    logic [NAME_W-1:0] tab_name[$];
    logic [NBITS-1:0]  tab_in1[$];
    logic [NBITS-1:0]  tab_in2[$];
    logic [NBITS-1:0]  tab_result[$];
    logic              tab_inf[$];
    logic              tab_zero[$];

    tb_clock_gen u_clock
    (
        .clk    (clk),
        .arst_n (arst_n)
    );

    posit_add_top u_posit_add_top
    (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .in1    (in1),
        .in2    (in2),
        .result (result),
        .inf    (inf),
        .zero   (zero),
        .done   (done)
    );

    posit_add_checker #(.NAME_W(NAME_W)) u_checker
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start),
        .test_name   (test_name),
        .exp_result  (exp_result),
        .exp_inf     (exp_inf),
        .exp_zero    (exp_zero),
        .done        (done),
        .result      (result),
        .inf         (inf),
        .zero        (zero),
        .mismatches  (mismatches),
        .stray_dones (stray_dones),
        .pending     (pending)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic pick_gap(output int gap);
        lfsr_state = lfsr_next(lfsr_state);
        gap        = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        gap        = gap * 2 + lfsr_state[0];
    endtask

    task automatic add_entry(input logic [NAME_W-1:0] name, input logic [NBITS-1:0] a,
                             input logic [NBITS-1:0] b, input logic [NBITS-1:0] sum,
                             input logic is_inf, input logic is_zero);
        tab_name.push_back(name);
        tab_in1.push_back(a);
        tab_in2.push_back(b);
        tab_result.push_back(sum);
        tab_inf.push_back(is_inf);
        tab_zero.push_back(is_zero);
    endtask

    task automatic build_table();
        add_entry("one_plus_one",      32'h4000_0000, 32'h4000_0000, 32'h4400_0000, 0, 0);
        add_entry("one_plus_two",      32'h4000_0000, 32'h4400_0000, 32'h4600_0000, 0, 0);
        add_entry("half_plus_quarter", 32'h3C00_0000, 32'h3800_0000, 32'h3E00_0000, 0, 0);
        add_entry("one_plus_2e16",     32'h4000_0000, 32'h7000_0000, 32'h7000_0100, 0, 0);
        add_entry("2em16_twice",       32'h1000_0000, 32'h1000_0000, 32'h1200_0000, 0, 0);
        add_entry("neg_one_twice",     32'hC000_0000, 32'hC000_0000, 32'hBC00_0000, 0, 0);
        // Subtraction and cancellation
        add_entry("three_minus_three", 32'h4600_0000, 32'hBA00_0000, 32'h0000_0000, 0, 1);
        add_entry("three_minus_one",   32'h4600_0000, 32'hC000_0000, 32'h4400_0000, 0, 0);
        add_entry("one_minus_three",   32'h4000_0000, 32'hBA00_0000, 32'hBC00_0000, 0, 0);
        add_entry("2e16_minus_one",    32'h7000_0000, 32'hC000_0000, 32'h6FFF_FC00, 0, 0);
        // Large scales where only exponent bits remain
        add_entry("tie_stays_even",    32'h7FFF_FFF0, 32'h7FFF_FFEE, 32'h7FFF_FFF0, 0, 0);
        add_entry("tie_rounds_even",   32'h7FFF_FFF1, 32'h7FFF_FFF0, 32'h7FFF_FFF2, 0, 0);
        add_entry("above_half_up",     32'h7FFF_FFF0, 32'h7FFF_FFEF, 32'h7FFF_FFF1, 0, 0);
        add_entry("maxpos_saturates",  32'h7FFF_FFFF, 32'h7FFF_FFFF, 32'h7FFF_FFFF, 0, 0);
        // Special operands
        add_entry("zero_plus_three",   32'h0000_0000, 32'h4600_0000, 32'h4600_0000, 0, 0);
        add_entry("nar_plus_one",      32'h8000_0000, 32'h4000_0000, 32'h8000_0000, 1, 0);
        add_entry("zero_plus_nar",     32'h0000_0000, 32'h8000_0000, 32'h8000_0000, 1, 0);
        add_entry("zero_plus_zero",    32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 0, 1);
    endtask

    initial
    begin
        int waited;
        int gap;
        int total;
        start      = 1'b0;
        in1        = '0;
        in2        = '0;
        test_name  = '0;
        exp_result = '0;
        exp_inf    = 1'b0;
        exp_zero   = 1'b0;
        timeouts   = 0;
        lfsr_state = 16'd28614;
        build_table();

        waited = 0;
        while (arst_n !== 1'b1 && waited < RESET_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end

        if (arst_n !== 1'b1)
        begin
            $display("Reset was never released");
            timeouts++;
        end
        else
        begin
            @(negedge clk);
            for (int i = 0; i < tab_name.size(); i++)
            begin
                start      = 1'b1;
                in1        = tab_in1[i];
                in2        = tab_in2[i];
                test_name  = tab_name[i];
                exp_result = tab_result[i];
                exp_inf    = tab_inf[i];
                exp_zero   = tab_zero[i];
                @(negedge clk);
                start = 1'b0;
                pick_gap(gap);               // 0 gives back-to-back starts
                repeat (gap) @(negedge clk);
            end

            waited = 0;
            while (pending != 0 && waited < DRAIN_LIMIT)
            begin
                @(negedge clk);
                waited++;
            end
            if (pending != 0)
            begin
                $display("The done strobes stopped with %0d results outstanding", pending);
                timeouts++;
            end
            repeat (LATENCY + 2) @(negedge clk);   // Quiet period for stray dones
        end

        total = mismatches + stray_dones + pending + timeouts + u_posit_add_top.u_sva.failures;
        $display("Errors: %0d mismatch, %0d stray done, %0d unanswered, %0d timeout, %0d assertion",
                 mismatches, stray_dones, pending, timeouts, u_posit_add_top.u_sva.failures);
        if (total == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* posit_add.f */
posit_pkg.sv
posit_extract.sv
leading_one_detect.sv
posit_align_add.sv
posit_round_pack.sv
posit_add_top.sv
tb_clock_gen.sv
posit_add_checker.sv
posit_add_sva.sv
posit_add_tb.sv

/* Bender.yml */
package:
  name: posit_add

sources:
  - files:
      - posit_pkg.sv
      - posit_extract.sv
      - leading_one_detect.sv
      - posit_align_add.sv
      - posit_round_pack.sv
      - posit_add_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - posit_add_checker.sv
      - posit_add_sva.sv
      - posit_add_tb.sv
